//--- common/mm_cfg.svh
`ifndef MM_CFG_SVH
`define MM_CFG_SVH

// Datapath geometry
`define MM_DWIDTH        8
`define MM_SIZE          4
`define MM_IDX_WIDTH     2
`define MM_ACC_WIDTH     16
`define MM_AWIDTH        6
`define MM_DEPTH         (1 << `MM_AWIDTH)
`define MM_STRIDE_WIDTH  16
`define MM_STRIDE_RESET  4

// APB register file
`define MM_REG_AWIDTH    8
`define MM_REG_DWIDTH    32
`define MM_REG_CTRL      8'h04
`define MM_REG_A_ADDR    8'h0e
`define MM_REG_B_ADDR    8'h12
`define MM_REG_C_ADDR    8'h16
`define MM_REG_A_STRIDE  8'h28
`define MM_REG_B_STRIDE  8'h32
`define MM_REG_C_STRIDE  8'h03

// External buffer selects
`define MM_SEL_A         2'd0
`define MM_SEL_B         2'd1
`define MM_SEL_C         2'd2

`endif

//--- common/mm_reg_pkg.sv
`include "mm_cfg.svh"

package mm_reg_pkg;

  ////////////////////
  // APB side types
  ////////////////////

  // Register offset on PADDR
  typedef logic [`MM_REG_AWIDTH-1:0] reg_addr_t;

  // Register data on PWDATA and PRDATA
  typedef logic [`MM_REG_DWIDTH-1:0] reg_data_t;

  // Setup phase is taken in idle, access phase in write or read
  typedef enum logic [1:0] {
    apb_idle,
    apb_write,
    apb_read
  } apb_state_t;

endpackage

//--- common/mm_data_pkg.sv
`include "mm_cfg.svh"

package mm_data_pkg;

  ////////////////////
  // Datapath types
  ////////////////////

  typedef logic [`MM_DWIDTH-1:0] elem_t;

  // One matrix row, element 0 in the low byte
  typedef logic [`MM_SIZE*`MM_DWIDTH-1:0] word_t;

  typedef logic [`MM_AWIDTH-1:0]       addr_t;
  typedef logic [`MM_STRIDE_WIDTH-1:0] stride_t;
  typedef logic [`MM_ACC_WIDTH-1:0]    acc_t;
  typedef logic [`MM_IDX_WIDTH-1:0]    idx_t;

  // Sequencer states
  typedef enum logic [1:0] {
    seq_idle,
    seq_run,
    seq_drain,
    seq_done
  } seq_state_t;

endpackage

//--- hw/apb_regs.sv
`timescale 1ns/10ps
`include "mm_cfg.svh"

module apb_regs (
  input  logic                   clk,
  input  logic                   PRESETn,
  input  mm_reg_pkg::reg_addr_t  PADDR,
  input  logic                   PWRITE,
  input  logic                   PSEL,
  input  logic                   PENABLE,
  input  mm_reg_pkg::reg_data_t  PWDATA,
  output mm_reg_pkg::reg_data_t  PRDATA,
  output logic                   PREADY,
  input  logic                   busy,
  input  logic                   done,
  output logic                   start,
  output logic                   clear_done,
  output mm_data_pkg::addr_t     base_a,
  output mm_data_pkg::addr_t     base_b,
  output mm_data_pkg::addr_t     base_c,
  output mm_data_pkg::stride_t   stride_a,
  output mm_data_pkg::stride_t   stride_b,
  output mm_data_pkg::stride_t   stride_c
);

  mm_reg_pkg::apb_state_t state;
  mm_reg_pkg::reg_data_t  scratch;
  mm_reg_pkg::reg_data_t  rd_value;

  ////////////////////
  // Read mux
  ////////////////////
  always_comb begin
    case (PADDR)
      `MM_REG_CTRL:     rd_value = {done, {(`MM_REG_DWIDTH-2){1'b0}}, busy};
      `MM_REG_A_ADDR:   rd_value = mm_reg_pkg::reg_data_t'(base_a);
      `MM_REG_B_ADDR:   rd_value = mm_reg_pkg::reg_data_t'(base_b);
      `MM_REG_C_ADDR:   rd_value = mm_reg_pkg::reg_data_t'(base_c);
      `MM_REG_A_STRIDE: rd_value = mm_reg_pkg::reg_data_t'(stride_a);
      `MM_REG_B_STRIDE: rd_value = mm_reg_pkg::reg_data_t'(stride_b);
      `MM_REG_C_STRIDE: rd_value = mm_reg_pkg::reg_data_t'(stride_c);
      default:          rd_value = scratch;
    endcase
  end

  ////////////////////
  // Transfer FSM
  ////////////////////
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state      <= mm_reg_pkg::apb_idle;
      PRDATA     <= '0;
      PREADY     <= 1'b0;
      start      <= 1'b0;
      clear_done <= 1'b0;
      base_a     <= '0;
      base_b     <= '0;
      base_c     <= '0;
      stride_a   <= `MM_STRIDE_RESET;
      stride_b   <= `MM_STRIDE_RESET;
      stride_c   <= `MM_STRIDE_RESET;
      scratch    <= '0;
    end else begin
      // Response lasts a single cycle
      PRDATA <= '0;
      PREADY <= 1'b0;
      case (state)
        mm_reg_pkg::apb_idle: begin
          if (PSEL && !PENABLE) begin
            state <= PWRITE ? mm_reg_pkg::apb_write : mm_reg_pkg::apb_read;
          end
        end
        mm_reg_pkg::apb_write: begin
          if (PSEL && PENABLE && PWRITE) begin
            PREADY <= 1'b1;
            case (PADDR)
              `MM_REG_CTRL: begin
                start      <= PWDATA[0];
                clear_done <= PWDATA[`MM_REG_DWIDTH-1];
              end
              `MM_REG_A_ADDR:   base_a   <= PWDATA[`MM_AWIDTH-1:0];
              `MM_REG_B_ADDR:   base_b   <= PWDATA[`MM_AWIDTH-1:0];
              `MM_REG_C_ADDR:   base_c   <= PWDATA[`MM_AWIDTH-1:0];
              `MM_REG_A_STRIDE: stride_a <= PWDATA[`MM_STRIDE_WIDTH-1:0];
              `MM_REG_B_STRIDE: stride_b <= PWDATA[`MM_STRIDE_WIDTH-1:0];
              `MM_REG_C_STRIDE: stride_c <= PWDATA[`MM_STRIDE_WIDTH-1:0];
              default:          scratch  <= PWDATA;
            endcase
          end
          state <= mm_reg_pkg::apb_idle;
        end
        mm_reg_pkg::apb_read: begin
          if (PSEL && PENABLE && !PWRITE) begin
            PREADY <= 1'b1;
            PRDATA <= rd_value;
          end
          state <= mm_reg_pkg::apb_idle;
        end
        default: state <= mm_reg_pkg::apb_idle;
      endcase
    end
  end

  // Every transfer needs a fresh setup phase, so ready never repeats
  a_pready_pulse: assert property (@(posedge clk) disable iff (!PRESETn)
    PREADY |=> !PREADY)
    else $error("PREADY held high for two cycles");

endmodule

//--- hw/tile_ram.sv
`timescale 1ns/10ps
`include "mm_cfg.svh"

module tile_ram (
  input  logic               clk,
  input  mm_data_pkg::addr_t addr0,
  input  mm_data_pkg::word_t wdata0,
  input  logic               we0,
  output mm_data_pkg::word_t rdata0,
  input  mm_data_pkg::addr_t addr1,
  input  mm_data_pkg::word_t wdata1,
  input  logic               we1,
  output mm_data_pkg::word_t rdata1
);

  mm_data_pkg::word_t mem [`MM_DEPTH];

  ////////////////////
  // Storage
  ////////////////////

  // Both ports in one process
  // Port 1 wins a same-address write collision
  always_ff @(posedge clk) begin
    if (we0) begin
      mem[addr0] <= wdata0;
    end
    if (we1) begin
      mem[addr1] <= wdata1;
    end
    // Old data on read during write
    rdata0 <= mem[addr0];
    rdata1 <= mem[addr1];
  end

endmodule

//--- engine/mat_seq.sv
`timescale 1ns/10ps
`include "mm_cfg.svh"

module mat_seq (
  input  logic                 clk,
  input  logic                 PRESETn,
  input  logic                 start,
  input  logic                 clear_done,
  input  mm_data_pkg::addr_t   base_a,
  input  mm_data_pkg::addr_t   base_b,
  input  mm_data_pkg::addr_t   base_c,
  input  mm_data_pkg::stride_t stride_a,
  input  mm_data_pkg::stride_t stride_b,
  input  mm_data_pkg::stride_t stride_c,
  output mm_data_pkg::addr_t   a_rd_addr,
  output mm_data_pkg::addr_t   b_rd_addr,
  output logic                 acc_first,
  output logic                 acc_last,
  output mm_data_pkg::addr_t   row_c_addr,
  output logic                 busy,
  output logic                 done
);

  localparam int CNT_W = 2 * `MM_IDX_WIDTH;
  localparam int DRAIN = 2;

  mm_data_pkg::seq_state_t state;
  logic [CNT_W-1:0]        beat_cnt;
  mm_data_pkg::idx_t       row_i;
  mm_data_pkg::idx_t       inner_k;
  logic                    issue;

  // Base plus idx rows, wraps within the buffer
  function automatic mm_data_pkg::addr_t row_addr(
    input mm_data_pkg::addr_t   base,
    input mm_data_pkg::idx_t    idx,
    input mm_data_pkg::stride_t stride
  );
    mm_data_pkg::stride_t offset;
    offset = stride * mm_data_pkg::stride_t'(idx);
    return base + mm_data_pkg::addr_t'(offset);
  endfunction

  ////////////////////
  // Address generation
  ////////////////////

  // Beat counter is {i, k}, k runs fastest
  assign row_i   = beat_cnt[CNT_W-1:`MM_IDX_WIDTH];
  assign inner_k = beat_cnt[`MM_IDX_WIDTH-1:0];
  assign issue   = (state == mm_data_pkg::seq_run);

  assign a_rd_addr = row_addr(base_a, row_i, stride_a);
  assign b_rd_addr = row_addr(base_b, inner_k, stride_b);

  // Aligned with the buffer read data
  always_ff @(posedge clk) begin
    row_c_addr <= row_addr(base_c, row_i, stride_c);
  end

  ////////////////////
  // Sequencer FSM
  ////////////////////
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state     <= mm_data_pkg::seq_idle;
      beat_cnt  <= '0;
      acc_first <= 1'b0;
      acc_last  <= 1'b0;
    end else begin
      acc_first <= issue && (inner_k == '0);
      acc_last  <= issue && (inner_k == '1);
      case (state)
        mm_data_pkg::seq_idle: begin
          beat_cnt <= '0;
          if (start && !done) begin
            state <= mm_data_pkg::seq_run;
          end
        end
        mm_data_pkg::seq_run: begin
          // Counter wraps to zero for the drain phase
          beat_cnt <= beat_cnt + 1'b1;
          if (beat_cnt == '1) begin
            state <= mm_data_pkg::seq_drain;
          end
        end
        mm_data_pkg::seq_drain: begin
          beat_cnt <= beat_cnt + 1'b1;
          if (beat_cnt == CNT_W'(DRAIN - 1)) begin
            beat_cnt <= '0;
            state    <= mm_data_pkg::seq_done;
          end
        end
        mm_data_pkg::seq_done: begin
          if (clear_done) begin
            state <= mm_data_pkg::seq_idle;
          end
        end
        default: state <= mm_data_pkg::seq_idle;
      endcase
    end
  end

  assign busy = (state == mm_data_pkg::seq_run) || (state == mm_data_pkg::seq_drain);
  assign done = (state == mm_data_pkg::seq_done);

  // Delayed beat flags must never spill past the drain phase
  a_beat_in_busy: assert property (@(posedge clk) disable iff (!PRESETn)
    (acc_first || acc_last) |-> busy)
    else $error("Beat flag outside run or drain");

endmodule

//--- engine/mac_row.sv
`timescale 1ns/10ps
`include "mm_cfg.svh"

module mac_row (
  input  logic               clk,
  input  logic               PRESETn,
  input  mm_data_pkg::word_t a_row,
  input  mm_data_pkg::word_t b_row,
  input  logic               acc_first,
  input  logic               acc_last,
  input  mm_data_pkg::addr_t row_c_addr,
  output logic               c_we,
  output mm_data_pkg::addr_t c_addr,
  output mm_data_pkg::word_t c_data
);

  mm_data_pkg::idx_t  k_cnt;
  mm_data_pkg::idx_t  k_sel;
  mm_data_pkg::elem_t a_elem;
  mm_data_pkg::acc_t  acc      [`MM_SIZE];
  mm_data_pkg::acc_t  acc_next [`MM_SIZE];
  mm_data_pkg::word_t row_trunc;

  // A lane k feeds every column this beat
  assign k_sel  = acc_first ? '0 : k_cnt;
  assign a_elem = a_row[k_sel*`MM_DWIDTH +: `MM_DWIDTH];

  ////////////////////
  // Lane arithmetic
  ////////////////////
  always_comb begin
    for (int j = 0; j < `MM_SIZE; j++) begin
      acc_next[j] = (acc_first ? '0 : acc[j])
                  + mm_data_pkg::acc_t'(a_elem)
                  * mm_data_pkg::acc_t'(b_row[j*`MM_DWIDTH +: `MM_DWIDTH]);
      // C keeps the low byte only
      row_trunc[j*`MM_DWIDTH +: `MM_DWIDTH] = acc_next[j][`MM_DWIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      k_cnt <= '0;
      c_we  <= 1'b0;
    end else begin
      k_cnt <= k_sel + 1'b1;
      c_we  <= acc_last;
    end
  end

  // Accumulators and result row
  always_ff @(posedge clk) begin
    for (int j = 0; j < `MM_SIZE; j++) begin
      acc[j] <= acc_next[j];
    end
    if (acc_last) begin
      c_addr <= row_c_addr;
      c_data <= row_trunc;
    end
  end

endmodule

//--- hw/matmul_top.sv
`timescale 1ns/10ps
`include "mm_cfg.svh"

module matmul_top (
  input  logic                  clk,
  input  logic                  PRESETn,
  input  mm_reg_pkg::reg_addr_t PADDR,
  input  logic                  PWRITE,
  input  logic                  PSEL,
  input  logic                  PENABLE,
  input  mm_reg_pkg::reg_data_t PWDATA,
  output mm_reg_pkg::reg_data_t PRDATA,
  output logic                  PREADY,
  input  logic [1:0]            buf_select,
  input  mm_data_pkg::addr_t    buf_addr,
  input  mm_data_pkg::word_t    buf_wdata,
  input  logic                  buf_we,
  output mm_data_pkg::word_t    buf_rdata
);

  logic                 start;
  logic                 clear_done;
  logic                 busy;
  logic                 done;
  mm_data_pkg::addr_t   base_a;
  mm_data_pkg::addr_t   base_b;
  mm_data_pkg::addr_t   base_c;
  mm_data_pkg::stride_t stride_a;
  mm_data_pkg::stride_t stride_b;
  mm_data_pkg::stride_t stride_c;

  mm_data_pkg::addr_t   a_rd_addr;
  mm_data_pkg::addr_t   b_rd_addr;
  mm_data_pkg::word_t   a_row;
  mm_data_pkg::word_t   b_row;
  logic                 acc_first;
  logic                 acc_last;
  mm_data_pkg::addr_t   row_c_addr;
  logic                 c_we;
  mm_data_pkg::addr_t   c_addr;
  mm_data_pkg::word_t   c_data;

  logic                 ext_we_a;
  logic                 ext_we_b;
  logic                 ext_we_c;
  mm_data_pkg::word_t   ext_rdata_a;
  mm_data_pkg::word_t   ext_rdata_b;
  mm_data_pkg::word_t   ext_rdata_c;
  logic [1:0]           rd_sel;

  ////////////////////
  // External port
  ////////////////////
  assign ext_we_a = buf_we && (buf_select == `MM_SEL_A);
  assign ext_we_b = buf_we && (buf_select == `MM_SEL_B);
  assign ext_we_c = buf_we && (buf_select == `MM_SEL_C);

  // Select follows the address into the read cycle
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      rd_sel <= `MM_SEL_A;
    end else begin
      rd_sel <= buf_select;
    end
  end

  always_comb begin
    case (rd_sel)
      `MM_SEL_A: buf_rdata = ext_rdata_a;
      `MM_SEL_B: buf_rdata = ext_rdata_b;
      `MM_SEL_C: buf_rdata = ext_rdata_c;
      default:   buf_rdata = '0;
    endcase
  end

  ////////////////////
  // Control
  ////////////////////
  apb_regs u_apb_regs (
    .clk(clk), .PRESETn(PRESETn),
    .PADDR(PADDR), .PWRITE(PWRITE), .PSEL(PSEL), .PENABLE(PENABLE),
    .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY),
    .busy(busy), .done(done), .start(start), .clear_done(clear_done),
    .base_a(base_a), .base_b(base_b), .base_c(base_c),
    .stride_a(stride_a), .stride_b(stride_b), .stride_c(stride_c)
  );

  mat_seq u_mat_seq (
    .clk(clk), .PRESETn(PRESETn), .start(start), .clear_done(clear_done),
    .base_a(base_a), .base_b(base_b), .base_c(base_c),
    .stride_a(stride_a), .stride_b(stride_b), .stride_c(stride_c),
    .a_rd_addr(a_rd_addr), .b_rd_addr(b_rd_addr),
    .acc_first(acc_first), .acc_last(acc_last), .row_c_addr(row_c_addr),
    .busy(busy), .done(done)
  );

  mac_row u_mac_row (
    .clk(clk), .PRESETn(PRESETn), .a_row(a_row), .b_row(b_row),
    .acc_first(acc_first), .acc_last(acc_last), .row_c_addr(row_c_addr),
    .c_we(c_we), .c_addr(c_addr), .c_data(c_data)
  );

  ////////////////////
  // Tile buffers
  ////////////////////

  // Engine only reads A and B
  tile_ram u_ram_a (
    .clk(clk), .addr0(a_rd_addr), .wdata0('0), .we0(1'b0), .rdata0(a_row),
    .addr1(buf_addr), .wdata1(buf_wdata), .we1(ext_we_a), .rdata1(ext_rdata_a)
  );

  tile_ram u_ram_b (
    .clk(clk), .addr0(b_rd_addr), .wdata0('0), .we0(1'b0), .rdata0(b_row),
    .addr1(buf_addr), .wdata1(buf_wdata), .we1(ext_we_b), .rdata1(ext_rdata_b)
  );

  // Engine only writes C
  tile_ram u_ram_c (
    .clk(clk), .addr0(c_addr), .wdata0(c_data), .we0(c_we), .rdata0(),
    .addr1(buf_addr), .wdata1(buf_wdata), .we1(ext_we_c), .rdata1(ext_rdata_c)
  );

endmodule

//--- test/tb_matmul_top.sv
`timescale 1ns/10ps
`include "mm_cfg.svh"

module tb_matmul_top;

  localparam int APB_TIMEOUT = 8;
  localparam int DONE_POLLS  = 64;
  localparam int MAX_CASES   = 16;

  logic                  clk = 1'b0;
  logic                  PRESETn;
  mm_reg_pkg::reg_addr_t PADDR;
  logic                  PWRITE;
  logic                  PSEL;
  logic                  PENABLE;
  mm_reg_pkg::reg_data_t PWDATA;
  mm_reg_pkg::reg_data_t PRDATA;
  logic                  PREADY;
  logic [1:0]            buf_select;
  mm_data_pkg::addr_t    buf_addr;
  mm_data_pkg::word_t    buf_wdata;
  logic                  buf_we;
  mm_data_pkg::word_t    buf_rdata;

  int                    golden_fd;
  // Bases and strides of the current case
  mm_reg_pkg::reg_data_t cfg_val [6];
  // A rows, B rows, expected C rows
  mm_data_pkg::word_t    row_val [12];

  matmul_top u_dut (
    .clk(clk), .PRESETn(PRESETn),
    .PADDR(PADDR), .PWRITE(PWRITE), .PSEL(PSEL), .PENABLE(PENABLE),
    .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY),
    .buf_select(buf_select), .buf_addr(buf_addr), .buf_wdata(buf_wdata),
    .buf_we(buf_we), .buf_rdata(buf_rdata)
  );

  always #2 clk = ~clk;

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    assert (got === expected) else begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, expected);
      abort_run();
    end
  endtask

  // Row address is base plus idx strides modulo the buffer depth
  function automatic mm_data_pkg::addr_t row_address(input mm_reg_pkg::reg_data_t base,
                                                     input int idx,
                                                     input mm_reg_pkg::reg_data_t stride);
    int linear;
    linear = int'(base) + idx * int'(stride);
    return mm_data_pkg::addr_t'(linear % `MM_DEPTH);
  endfunction

  function automatic mm_data_pkg::word_t sentinel(input mm_data_pkg::addr_t addr);
    return 32'h5a5a_0000 | {26'd0, addr};
  endfunction

  function automatic mm_reg_pkg::reg_addr_t cfg_offset(input int idx);
    case (idx)
      0:       return `MM_REG_A_ADDR;
      1:       return `MM_REG_B_ADDR;
      2:       return `MM_REG_C_ADDR;
      3:       return `MM_REG_A_STRIDE;
      4:       return `MM_REG_B_STRIDE;
      default: return `MM_REG_C_STRIDE;
    endcase
  endfunction

  ////////////////////
  // Bus tasks
  ////////////////////
  task automatic wait_ready(input mm_reg_pkg::reg_addr_t addr);
    int waited;
    waited = 0;
    @(posedge clk);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
    while (PREADY !== 1'b1) begin
      if (waited == APB_TIMEOUT) begin
        $display("No PREADY for offset %h within %0d cycles", addr, APB_TIMEOUT);
        abort_run();
      end
      waited++;
      @(posedge clk);
    end
  endtask

  task automatic apb_write(input mm_reg_pkg::reg_addr_t addr,
                           input mm_reg_pkg::reg_data_t data);
    @(posedge clk);
    PADDR   <= addr;
    PWRITE  <= 1'b1;
    PWDATA  <= data;
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    @(posedge clk);
    PENABLE <= 1'b1;
    wait_ready(addr);
  endtask

  task automatic apb_read(input mm_reg_pkg::reg_addr_t addr,
                          output mm_reg_pkg::reg_data_t data);
    @(posedge clk);
    PADDR   <= addr;
    PWRITE  <= 1'b0;
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    @(posedge clk);
    PENABLE <= 1'b1;
    wait_ready(addr);
    data = PRDATA;
  endtask

  task automatic buf_write(input logic [1:0] sel, input mm_data_pkg::addr_t addr,
                           input mm_data_pkg::word_t data);
    @(posedge clk);
    buf_select <= sel;
    buf_addr   <= addr;
    buf_wdata  <= data;
    buf_we     <= 1'b1;
    @(posedge clk);
    buf_we     <= 1'b0;
  endtask

  // One cycle of buffer latency
  task automatic buf_read(input logic [1:0] sel, input mm_data_pkg::addr_t addr,
                          output mm_data_pkg::word_t data);
    @(posedge clk);
    buf_select <= sel;
    buf_addr   <= addr;
    buf_we     <= 1'b0;
    @(posedge clk);
    @(posedge clk);
    data = buf_rdata;
  endtask

  ////////////////////
  // Golden file
  ////////////////////
  task automatic next_line(output string line, output bit found);
    int skipped;
    found   = 1'b0;
    skipped = 0;
    while (!found && skipped < 64) begin
      if ($fgets(line, golden_fd) == 0) begin
        return;
      end
      if (line.len() > 1 && line[0] != "#") begin
        found = 1'b1;
      end else begin
        skipped++;
      end
    end
  endtask

  task automatic read_case(output bit found);
    string line;
    bit    got;
    next_line(line, found);
    if (!found) begin
      return;
    end
    if ($sscanf(line, "%h %h %h %h %h %h", cfg_val[0], cfg_val[1], cfg_val[2],
                cfg_val[3], cfg_val[4], cfg_val[5]) != 6) begin
      $display("Golden file has a malformed configuration line");
      abort_run();
    end
    for (int r = 0; r < 12; r++) begin
      next_line(line, got);
      if (!got || $sscanf(line, "%h", row_val[r]) != 1) begin
        $display("Golden file ends inside a case or has a malformed row");
        abort_run();
      end
    end
  endtask

  task automatic run_case(input int n);
    mm_data_pkg::addr_t    c_row [`MM_SIZE];
    mm_data_pkg::addr_t    guard;
    mm_reg_pkg::reg_data_t status;
    mm_data_pkg::word_t    got;
    int                    polls;
    // Load operands and scramble the stale C rows with a sentinel after each
    for (int i = 0; i < `MM_SIZE; i++) begin
      c_row[i] = row_address(cfg_val[2], i, cfg_val[5]);
      guard    = c_row[i] + 1'b1;
      buf_write(`MM_SEL_A, row_address(cfg_val[0], i, cfg_val[3]), row_val[i]);
      buf_write(`MM_SEL_B, row_address(cfg_val[1], i, cfg_val[4]), row_val[4+i]);
      buf_write(`MM_SEL_C, c_row[i], ~row_val[8+i]);
      buf_write(`MM_SEL_C, guard, sentinel(guard));
    end
    for (int r = 0; r < 6; r++) begin
      apb_write(cfg_offset(r), cfg_val[r]);
    end
    apb_write(`MM_REG_CTRL, 32'h0000_0001);
    polls = 0;
    apb_read(`MM_REG_CTRL, status);
    while (status[31] !== 1'b1) begin
      if (polls == DONE_POLLS) begin
        $display("Case %0d never reported done after %0d status reads", n, polls);
        abort_run();
      end
      polls++;
      apb_read(`MM_REG_CTRL, status);
    end
    // Done holds and busy is gone
    check_word("PRDATA (CTRL at done)", status, 32'h8000_0000);
    for (int r = 0; r < 3; r++) begin
      apb_read(`MM_REG_CTRL, status);
      check_word("PRDATA (CTRL held done)", status, 32'h8000_0000);
    end
    for (int i = 0; i < `MM_SIZE; i++) begin
      guard = c_row[i] + 1'b1;
      buf_read(`MM_SEL_C, c_row[i], got);
      check_word($sformatf("buf_rdata (case %0d C row %0d at %h)", n, i, c_row[i]),
                 got, row_val[8+i]);
      buf_read(`MM_SEL_C, guard, got);
      check_word($sformatf("buf_rdata (case %0d sentinel at %h)", n, guard),
                 got, sentinel(guard));
    end
    apb_write(`MM_REG_CTRL, 32'h8000_0000);
    apb_read(`MM_REG_CTRL, status);
    check_word("PRDATA (CTRL after clear)", status, 32'h0);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    mm_reg_pkg::reg_data_t rd;
    mm_reg_pkg::reg_data_t mask;
    mm_data_pkg::word_t    word;
    mm_data_pkg::word_t    got;
    mm_data_pkg::word_t    sel_word [3];
    int                    n_cases;
    bit                    found;
    PRESETn    = 1'b0;
    PADDR      = '0;
    PWRITE     = 1'b0;
    PSEL       = 1'b0;
    PENABLE    = 1'b0;
    PWDATA     = '0;
    buf_select = `MM_SEL_A;
    buf_addr   = '0;
    buf_wdata  = '0;
    buf_we     = 1'b0;
    void'($urandom(32'hb8f4_c9bd));
    golden_fd = $fopen("test/matmul_golden.txt", "r");
    if (golden_fd == 0) begin
      $display("Cannot open test/matmul_golden.txt");
      abort_run();
    end
    repeat (5) @(posedge clk);
    PRESETn <= 1'b1;
    @(posedge clk);
    check_word("PREADY after reset", {31'd0, PREADY}, 32'd0);

    // Reset values of every register and the scratch word
    apb_read(`MM_REG_CTRL, rd);
    check_word("PRDATA (CTRL after reset)", rd, 32'h0);
    for (int r = 0; r < 6; r++) begin
      apb_read(cfg_offset(r), rd);
      check_word($sformatf("PRDATA @%h after reset", cfg_offset(r)), rd,
                 (r < 3) ? 32'd0 : 32'(`MM_STRIDE_RESET));
    end
    apb_read(8'h40, rd);
    check_word("PRDATA (scratch after reset)", rd, 32'h0);

    // Write then read back each field masked to its width
    for (int r = 0; r < 6; r++) begin
      mask = (r < 3) ? (32'd1 << `MM_AWIDTH) - 32'd1 : (32'd1 << `MM_STRIDE_WIDTH) - 32'd1;
      word = $urandom();
      apb_write(cfg_offset(r), word);
      apb_read(cfg_offset(r), rd);
      check_word($sformatf("PRDATA @%h", cfg_offset(r)), rd, word & mask);
    end
    word = $urandom();
    apb_write(8'h40, word);
    apb_read(8'h7c, rd);
    check_word("PRDATA (scratch via 0x7c)", rd, word);

    // External port per select
    for (int s = 0; s < 3; s++) begin
      sel_word[s] = $urandom();
      buf_write(2'(s), 6'h3a, sel_word[s]);
      buf_read(2'(s), 6'h3a, got);
      check_word($sformatf("buf_rdata (select %0d)", s), got, sel_word[s]);
    end
    buf_write(2'd3, 6'h3a, ~sel_word[2]);
    // Each buffer keeps its own word
    for (int s = 0; s < 3; s++) begin
      buf_read(2'(s), 6'h3a, got);
      check_word($sformatf("buf_rdata (select %0d after all writes)", s),
                 got, sel_word[s]);
    end
    buf_read(2'd3, 6'h3a, got);
    check_word("buf_rdata (select 3)", got, 32'h0);

    n_cases = 0;
    read_case(found);
    while (found && n_cases < MAX_CASES) begin
      run_case(n_cases);
      n_cases++;
      read_case(found);
    end
    if (n_cases < 2) begin
      $display("Golden file holds %0d cases, at least two are needed", n_cases);
      abort_run();
    end else begin
      $fclose(golden_fd);
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

//--- test/matmul_golden.txt
# Per case: base_a base_b base_c stride_a stride_b stride_c (hex), then four A rows,
# four B rows and four expected C rows, one hex word each, element 0 in the low byte
# Case 0 with reset bases and strides
00 00 00 0004 0004 0004
04030201
08070605
0c0b0a09
100f0e0d
01020001
02010100
01000102
00010201
08080d0b
18181d1b
28282d2b
38383d3b
# Case 1 with odd strides, C rows wrap past the buffer end
10 21 30 0003 0045 0007
281e140a
193264c8
038001ff
63114d07
09070503
060402fa
ff000d0b
80402010
b496e070
ae485ab6
fdbddda7
7c25fa32

//--- matmul_top.f
+incdir+common
common/mm_reg_pkg.sv
common/mm_data_pkg.sv
hw/apb_regs.sv
hw/tile_ram.sv
engine/mat_seq.sv
engine/mac_row.sv
hw/matmul_top.sv
test/tb_matmul_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_matmul_top
FILELIST  ?= matmul_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard common/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
